/* verilog/mipsIsaPkg.sv */
package mipsIsaPkg;

  //////////////////////////////
  // Field widths
  //////////////////////////////

  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;
  localparam int opWidth      = 6;
  localparam int immWidth     = 16;
  localparam int jumpIdxWidth = 26;

  // Byte distance between two sequential instructions
  localparam logic [dataWidth-1:0] pcStep = 4;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  localparam logic [opWidth-1:0] opRType = 6'h00;
  localparam logic [opWidth-1:0] opJ     = 6'h02;
  localparam logic [opWidth-1:0] opBeq   = 6'h04;
  localparam logic [opWidth-1:0] opBne   = 6'h05;
  localparam logic [opWidth-1:0] opAddiu = 6'h09;
  localparam logic [opWidth-1:0] opAndi  = 6'h0c;
  localparam logic [opWidth-1:0] opOri   = 6'h0d;
  localparam logic [opWidth-1:0] opLui   = 6'h0f;

  // Funct field of R-type instructions
  localparam logic [opWidth-1:0] fnAddu = 6'h21;
  localparam logic [opWidth-1:0] fnSubu = 6'h23;
  localparam logic [opWidth-1:0] fnAnd  = 6'h24;
  localparam logic [opWidth-1:0] fnOr   = 6'h25;
  localparam logic [opWidth-1:0] fnSlt  = 6'h2a;

  // ALU operations
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluLui
  } aluOpT;

endpackage

/* verilog/pipePkg.sv */
package pipePkg;

  //////////////////////////////
  // Stage register payloads
  //////////////////////////////

  // Fetch to decode
  typedef struct packed {
    logic                                valid;
    logic [mipsIsaPkg::dataWidth-1:0]    pc;
    logic [mipsIsaPkg::dataWidth-1:0]    instr;
  } ifIdT;

  // Decode to execute
  typedef struct packed {
    logic                                valid;
    logic [mipsIsaPkg::dataWidth-1:0]    pc;
    logic [mipsIsaPkg::dataWidth-1:0]    rsData;
    logic [mipsIsaPkg::dataWidth-1:0]    rtData;
    logic [mipsIsaPkg::dataWidth-1:0]    imm;
    mipsIsaPkg::aluOpT                   aluOp;
    logic                                useImm;
    logic                                regWrite;
    logic [mipsIsaPkg::regAddrWidth-1:0] destReg;
    logic                                isBeq;
    logic                                isBne;
    logic                                isJump;
    logic [mipsIsaPkg::jumpIdxWidth-1:0] jumpIndex;
  } idExT;

  // Execute to writeback
  typedef struct packed {
    logic                                valid;
    logic                                regWrite;
    logic [mipsIsaPkg::regAddrWidth-1:0] destReg;
    logic [mipsIsaPkg::dataWidth-1:0]    result;
  } exWbT;

  //////////////////////////////
  // Control flow
  //////////////////////////////

  // Taken branch or jump seen in execute
  typedef struct packed {
    logic                                valid;
    logic [mipsIsaPkg::dataWidth-1:0]    target;
  } redirectT;

endpackage

/* verilog/pipeStageReg.sv */
`timescale 1ns/1ps

// Generic pipeline register
// A flush turns the next entry into a bubble
module pipeStageReg #(
  parameter type payloadT = logic [7:0]
) (
  input  logic    Clk,
  input  logic    rstN,
  input  logic    flush,
  input  payloadT d,
  output payloadT q
);

  // All-zero payload is a bubble for every stage type
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;
    end else begin
      q <= d;
    end
  end

endmodule

/* verilog/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
  input  pipePkg::ifIdT                             ifId,
  output logic [mipsIsaPkg::regAddrWidth-1:0]       rsAddr,
  output logic [mipsIsaPkg::regAddrWidth-1:0]       rtAddr,
  input  logic [mipsIsaPkg::dataWidth-1:0]          rsData,
  input  logic [mipsIsaPkg::dataWidth-1:0]          rtData,
  output pipePkg::idExT                             idEx
);

  logic [mipsIsaPkg::opWidth-1:0]      opcode;
  logic [mipsIsaPkg::opWidth-1:0]      funct;
  logic [mipsIsaPkg::regAddrWidth-1:0] rdAddr;
  logic [mipsIsaPkg::immWidth-1:0]     imm16;
  logic [mipsIsaPkg::dataWidth-1:0]    immSext;
  logic [mipsIsaPkg::dataWidth-1:0]    immZext;

  //////////////////////////////
  // Instruction fields
  //////////////////////////////

  assign opcode = ifId.instr[31:26];
  assign rsAddr = ifId.instr[25:21];
  assign rtAddr = ifId.instr[20:16];
  assign rdAddr = ifId.instr[15:11];
  assign funct  = ifId.instr[5:0];
  assign imm16  = ifId.instr[15:0];

  assign immSext = {{(mipsIsaPkg::dataWidth-mipsIsaPkg::immWidth){imm16[15]}}, imm16};
  assign immZext = {{(mipsIsaPkg::dataWidth-mipsIsaPkg::immWidth){1'b0}}, imm16};

  //////////////////////////////
  // Control decode
  //////////////////////////////

  always_comb begin
    idEx           = '0;
    idEx.valid     = ifId.valid;
    idEx.pc        = ifId.pc;
    idEx.rsData    = rsData;
    idEx.rtData    = rtData;
    idEx.jumpIndex = ifId.instr[mipsIsaPkg::jumpIdxWidth-1:0];
    idEx.aluOp     = mipsIsaPkg::aluAdd;

    // Bubbles carry no write and no branch flags
    if (ifId.valid) begin
      case (opcode)
        mipsIsaPkg::opRType: begin
          idEx.destReg  = rdAddr;
          idEx.regWrite = 1'b1;
          case (funct)
            mipsIsaPkg::fnAddu: idEx.aluOp = mipsIsaPkg::aluAdd;
            mipsIsaPkg::fnSubu: idEx.aluOp = mipsIsaPkg::aluSub;
            mipsIsaPkg::fnAnd:  idEx.aluOp = mipsIsaPkg::aluAnd;
            mipsIsaPkg::fnOr:   idEx.aluOp = mipsIsaPkg::aluOr;
            mipsIsaPkg::fnSlt:  idEx.aluOp = mipsIsaPkg::aluSlt;
            default:            idEx.regWrite = 1'b0;
          endcase
        end
        mipsIsaPkg::opAddiu: begin
          idEx.imm      = immSext;
          idEx.useImm   = 1'b1;
          idEx.regWrite = 1'b1;
          idEx.destReg  = rtAddr;
        end
        mipsIsaPkg::opAndi: begin
          idEx.imm      = immZext;
          idEx.useImm   = 1'b1;
          idEx.regWrite = 1'b1;
          idEx.destReg  = rtAddr;
          idEx.aluOp    = mipsIsaPkg::aluAnd;
        end
        mipsIsaPkg::opOri: begin
          idEx.imm      = immZext;
          idEx.useImm   = 1'b1;
          idEx.regWrite = 1'b1;
          idEx.destReg  = rtAddr;
          idEx.aluOp    = mipsIsaPkg::aluOr;
        end
        mipsIsaPkg::opLui: begin
          idEx.imm      = immZext;
          idEx.useImm   = 1'b1;
          idEx.regWrite = 1'b1;
          idEx.destReg  = rtAddr;
          idEx.aluOp    = mipsIsaPkg::aluLui;
        end
        mipsIsaPkg::opBeq: begin
          idEx.imm   = immSext;
          idEx.isBeq = 1'b1;
        end
        mipsIsaPkg::opBne: begin
          idEx.imm   = immSext;
          idEx.isBne = 1'b1;
        end
        mipsIsaPkg::opJ:   idEx.isJump = 1'b1;
        // Unknown opcode runs through as a no-op
        default: ;
      endcase
    end
  end

endmodule

/* verilog/regFile.sv */
`timescale 1ns/1ps

module regFile (
  input  logic                                Clk,
  input  logic                                rstN,
  input  logic [mipsIsaPkg::regAddrWidth-1:0] rsAddr,
  input  logic [mipsIsaPkg::regAddrWidth-1:0] rtAddr,
  output logic [mipsIsaPkg::dataWidth-1:0]    rsData,
  output logic [mipsIsaPkg::dataWidth-1:0]    rtData,
  input  logic                                wrEn,
  input  logic [mipsIsaPkg::regAddrWidth-1:0] wrAddr,
  input  logic [mipsIsaPkg::dataWidth-1:0]    wrData
);

  // r0 has no storage
  logic [mipsIsaPkg::dataWidth-1:0] regs [1:2**mipsIsaPkg::regAddrWidth-1];

  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < 2**mipsIsaPkg::regAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && wrAddr != '0) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Read with write-through so decode sees this cycle's writeback
  function automatic logic [mipsIsaPkg::dataWidth-1:0] readPort(
    input logic [mipsIsaPkg::regAddrWidth-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end else if (wrEn && wrAddr == addr) begin
      return wrData;
    end else begin
      return regs[addr];
    end
  endfunction

  always_comb begin
    rsData = readPort(rsAddr);
    rtData = readPort(rtAddr);
  end

  // Execute drops the write enable for r0 destinations
  wrNeverZero: assert property (@(posedge Clk) disable iff (!rstN)
    wrEn |-> wrAddr != '0)
    else $error("regFile write to r0");

endmodule

/* verilog/execUnit.sv */
`timescale 1ns/1ps

module execUnit (
  input  pipePkg::idExT     idEx,
  output pipePkg::exWbT     exWb,
  output pipePkg::redirectT redirect
);

  logic [mipsIsaPkg::dataWidth-1:0] opB;
  logic [mipsIsaPkg::dataWidth-1:0] aluResult;
  logic [mipsIsaPkg::dataWidth-1:0] pcPlus4;
  logic [mipsIsaPkg::dataWidth-1:0] branchTarget;
  logic [mipsIsaPkg::dataWidth-1:0] jumpTarget;
  logic                             operandsEqual;
  logic                             taken;

  //////////////////////////////
  // ALU
  //////////////////////////////

  assign opB = idEx.useImm ? idEx.imm : idEx.rtData;

  always_comb begin
    case (idEx.aluOp)
      mipsIsaPkg::aluAdd: aluResult = idEx.rsData + opB;
      mipsIsaPkg::aluSub: aluResult = idEx.rsData - opB;
      mipsIsaPkg::aluAnd: aluResult = idEx.rsData & opB;
      mipsIsaPkg::aluOr:  aluResult = idEx.rsData | opB;
      // Signed compare
      mipsIsaPkg::aluSlt: begin
        aluResult = {{(mipsIsaPkg::dataWidth-1){1'b0}},
                     $signed(idEx.rsData) < $signed(opB)};
      end
      mipsIsaPkg::aluLui: begin
        aluResult = {idEx.imm[mipsIsaPkg::immWidth-1:0], {mipsIsaPkg::immWidth{1'b0}}};
      end
      default: aluResult = '0;
    endcase
  end

  assign exWb.valid    = idEx.valid;
  assign exWb.regWrite = idEx.regWrite && (idEx.destReg != '0);
  assign exWb.destReg  = idEx.destReg;
  assign exWb.result   = aluResult;

  //////////////////////////////
  // Branch and jump
  //////////////////////////////

  assign operandsEqual = (idEx.rsData == idEx.rtData);
  assign pcPlus4       = idEx.pc + mipsIsaPkg::pcStep;
  assign branchTarget  = pcPlus4 + {idEx.imm[mipsIsaPkg::dataWidth-3:0], 2'b00};
  assign jumpTarget    = {pcPlus4[mipsIsaPkg::dataWidth-1:mipsIsaPkg::dataWidth-4],
                          idEx.jumpIndex, 2'b00};

  // Flags are only ever set on valid entries by decode and flush
  assign taken = (idEx.isBeq && operandsEqual) ||
                 (idEx.isBne && !operandsEqual) ||
                 idEx.isJump;

  assign redirect.valid  = taken;
  assign redirect.target = idEx.isJump ? jumpTarget : branchTarget;

  always_comb begin
    redirectOnlyValid: assert #0 (!redirect.valid || idEx.valid)
      else $error("redirect from a bubble in execute");
  end

endmodule

/* verilog/pipeCore.sv */
`timescale 1ns/1ps

module pipeCore (
  input  logic                                Clk,
  input  logic                                rstN,
  input  logic                                instrValid,
  input  logic [mipsIsaPkg::dataWidth-1:0]    instr,
  input  logic [mipsIsaPkg::dataWidth-1:0]    pc,
  output logic                                wbValid,
  output logic [mipsIsaPkg::regAddrWidth-1:0] wbReg,
  output logic [mipsIsaPkg::dataWidth-1:0]    wbData,
  output logic                                redirectValid,
  output logic [mipsIsaPkg::dataWidth-1:0]    redirectTarget
);

  pipePkg::ifIdT     ifIdD;
  pipePkg::ifIdT     ifIdQ;
  pipePkg::idExT     idExD;
  pipePkg::idExT     idExQ;
  pipePkg::exWbT     exWbD;
  pipePkg::exWbT     exWbQ;
  pipePkg::redirectT redirect;

  logic [mipsIsaPkg::regAddrWidth-1:0] rsAddr;
  logic [mipsIsaPkg::regAddrWidth-1:0] rtAddr;
  logic [mipsIsaPkg::dataWidth-1:0]    rsData;
  logic [mipsIsaPkg::dataWidth-1:0]    rtData;

  assign ifIdD.valid = instrValid;
  assign ifIdD.pc    = pc;
  assign ifIdD.instr = instr;

  //////////////////////////////
  // Fetch / decode
  //////////////////////////////

  pipeStageReg #(.payloadT(pipePkg::ifIdT)) ifIdReg (
    .Clk(Clk), .rstN(rstN), .flush(redirect.valid), .d(ifIdD), .q(ifIdQ)
  );

  instrDecoder decoder (
    .ifId(ifIdQ), .rsAddr(rsAddr), .rtAddr(rtAddr),
    .rsData(rsData), .rtData(rtData), .idEx(idExD)
  );

  // Write port fed straight from EX/WB
  regFile regs (
    .Clk(Clk), .rstN(rstN), .rsAddr(rsAddr), .rtAddr(rtAddr),
    .rsData(rsData), .rtData(rtData),
    .wrEn(exWbQ.regWrite), .wrAddr(exWbQ.destReg), .wrData(exWbQ.result)
  );

  //////////////////////////////
  // Execute / writeback
  //////////////////////////////

  pipeStageReg #(.payloadT(pipePkg::idExT)) idExReg (
    .Clk(Clk), .rstN(rstN), .flush(redirect.valid), .d(idExD), .q(idExQ)
  );

  execUnit exec (
    .idEx(idExQ), .exWb(exWbD), .redirect(redirect)
  );

  // Branch itself still retires, with no write
  pipeStageReg #(.payloadT(pipePkg::exWbT)) exWbReg (
    .Clk(Clk), .rstN(rstN), .flush(1'b0), .d(exWbD), .q(exWbQ)
  );

  // regWrite already folds in valid and the r0 check
  assign wbValid        = exWbQ.regWrite;
  assign wbReg          = exWbQ.destReg;
  assign wbData         = exWbQ.result;
  assign redirectValid  = redirect.valid;
  assign redirectTarget = redirect.target;

endmodule

/* sim/pipeCoreTb.sv */
`timescale 1ns/1ps

module pipeCoreTb;

  typedef struct packed {
    logic [31:0] edgeN;
    logic [4:0]  dest;
    logic [31:0] data;
  } wbExpT;

  typedef struct packed {
    logic [31:0] edgeN;
    logic [31:0] target;
  } redirExpT;

  localparam int drainLimit = 20;

  logic                                Clk;
  logic                                rstN;
  logic                                instrValid;
  logic [mipsIsaPkg::dataWidth-1:0]    instr;
  logic [mipsIsaPkg::dataWidth-1:0]    pc;
  logic                                wbValid;
  logic [mipsIsaPkg::regAddrWidth-1:0] wbReg;
  logic [mipsIsaPkg::dataWidth-1:0]    wbData;
  logic                                redirectValid;
  logic [mipsIsaPkg::dataWidth-1:0]    redirectTarget;

  // Expected outputs for the coming rising edge
  wbExpT       expWb;
  logic        expWbValid;
  redirExpT    expRedir;
  logic        expRedirValid;

  // Reference model state
  logic [31:0] shadow [0:31];
  wbExpT       wbQ[$];
  redirExpT    redirQ[$];
  int unsigned edgeCount = 0;
  int unsigned killThrough;
  logic [31:0] pcNext;
  integer      seed;
  string       curTest;
  int          testErrors;
  int          testsRun;
  int          testsFailed;

  initial begin
    Clk = 1'b0;
    forever #5 Clk = ~Clk;
  end

  always @(posedge Clk) edgeCount <= edgeCount + 1;

  pipeCore pipeCore_inst (
    .Clk(Clk), .rstN(rstN), .instrValid(instrValid), .instr(instr), .pc(pc),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
    .redirectValid(redirectValid), .redirectTarget(redirectTarget)
  );

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic noteMismatch(input string what, input logic [31:0] expV,
                              input logic [31:0] actV);
    $display("FAILED %s %s: expected %h actual %h", curTest, what, expV, actV);
    testErrors++;
  endtask

  wbValidCheck: assert property (@(posedge Clk) disable iff (!rstN) wbValid == expWbValid)
    else noteMismatch("wbValid", 32'($sampled(expWbValid)), 32'($sampled(wbValid)));
  wbRegCheck: assert property (@(posedge Clk) disable iff (!rstN)
    expWbValid |-> wbReg == expWb.dest)
    else noteMismatch("wbReg", 32'($sampled(expWb.dest)), 32'($sampled(wbReg)));
  wbDataCheck: assert property (@(posedge Clk) disable iff (!rstN)
    expWbValid |-> wbData == expWb.data)
    else noteMismatch("wbData", $sampled(expWb.data), $sampled(wbData));
  redirValidCheck: assert property (@(posedge Clk) disable iff (!rstN)
    redirectValid == expRedirValid)
    else noteMismatch("redirectValid", 32'($sampled(expRedirValid)),
                      32'($sampled(redirectValid)));
  redirTargetCheck: assert property (@(posedge Clk) disable iff (!rstN)
    expRedirValid |-> redirectTarget == expRedir.target)
    else noteMismatch("redirectTarget", $sampled(expRedir.target), $sampled(redirectTarget));

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt);
    return {mipsIsaPkg::opRType, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rt,
                                       input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Applied in issue order; n is the edge that samples the instruction
  task automatic modelInstr(input logic [31:0] ins, input logic [31:0] ipc,
                            input int unsigned n);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] se;
    logic [31:0] ze;
    logic [31:0] res;
    logic [31:0] seqPc;
    logic [31:0] tgt;
    logic [4:0]  dst;
    logic        wr;
    logic        taken;
    wbExpT       w;
    redirExpT    r;
    // Squashed by an older taken branch
    if (n <= killThrough) return;
    a = shadow[ins[25:21]];
    b = shadow[ins[20:16]];
    se = {{16{ins[15]}}, ins[15:0]};
    ze = {16'h0, ins[15:0]};
    seqPc = ipc + 32'd4;
    res = '0;
    tgt = '0;
    dst = ins[20:16];
    wr = 1'b1;
    taken = 1'b0;
    case (ins[31:26])
      mipsIsaPkg::opRType: begin
        dst = ins[15:11];
        case (ins[5:0])
          mipsIsaPkg::fnAddu: res = a + b;
          mipsIsaPkg::fnSubu: res = a - b;
          mipsIsaPkg::fnAnd:  res = a & b;
          mipsIsaPkg::fnOr:   res = a | b;
          mipsIsaPkg::fnSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default:            wr = 1'b0;
        endcase
      end
      mipsIsaPkg::opAddiu: res = a + se;
      mipsIsaPkg::opAndi:  res = a & ze;
      mipsIsaPkg::opOri:   res = a | ze;
      mipsIsaPkg::opLui:   res = {ins[15:0], 16'h0};
      mipsIsaPkg::opBeq: begin
        wr = 1'b0;
        taken = (a == b);
        tgt = seqPc + (se << 2);
      end
      mipsIsaPkg::opBne: begin
        wr = 1'b0;
        taken = (a != b);
        tgt = seqPc + (se << 2);
      end
      mipsIsaPkg::opJ: begin
        wr = 1'b0;
        taken = 1'b1;
        tgt = {seqPc[31:28], ins[25:0], 2'b00};
      end
      default: wr = 1'b0;
    endcase
    if (wr && dst != 5'd0) begin
      shadow[dst] = res;
      w.edgeN = n + 3;
      w.dest = dst;
      w.data = res;
      wbQ.push_back(w);
    end
    if (taken) begin
      r.edgeN = n + 2;
      r.target = tgt;
      redirQ.push_back(r);
      // The next two fetch slots become bubbles
      killThrough = n + 2;
    end
  endtask

  task automatic setExpected(input int unsigned n);
    expWbValid = 1'b0;
    expRedirValid = 1'b0;
    if (wbQ.size() > 0 && wbQ[0].edgeN == n) begin
      expWb = wbQ.pop_front();
      expWbValid = 1'b1;
    end
    if (redirQ.size() > 0 && redirQ[0].edgeN == n) begin
      expRedir = redirQ.pop_front();
      expRedirValid = 1'b1;
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // One fetch slot, driven on the falling edge
  task automatic stepCycle(input logic v, input logic [31:0] ins);
    int unsigned n;
    @(negedge Clk);
    n = edgeCount + 1;
    if (v) modelInstr(ins, pcNext, n);
    setExpected(n);
    instrValid = v;
    instr = ins;
    pc = pcNext;
    if (v) pcNext = pcNext + 32'd4;
  endtask

  // Two issue cycles apart, enough for any dependency
  task automatic issue(input logic [31:0] ins);
    stepCycle(1'b1, ins);
    stepCycle(1'b0, 32'h0);
  endtask

  task automatic loadConst(input logic [4:0] rt, input logic [31:0] value);
    issue(encI(mipsIsaPkg::opLui, rt, 5'd0, value[31:16]));
    issue(encI(mipsIsaPkg::opOri, rt, rt, value[15:0]));
  endtask

  task automatic startTest(input string name);
    curTest = name;
    testErrors = 0;
  endtask

  task automatic finishTest();
    int waited;
    waited = 0;
    while ((wbQ.size() > 0 || redirQ.size() > 0) && waited < drainLimit) begin
      stepCycle(1'b0, 32'h0);
      waited++;
    end
    if (wbQ.size() > 0 || redirQ.size() > 0) begin
      $display("Timeout in %s: %0d writes and %0d redirects never seen",
               curTest, wbQ.size(), redirQ.size());
      wbQ.delete();
      redirQ.delete();
      testErrors++;
    end
    // Last expected edge still has to be sampled
    stepCycle(1'b0, 32'h0);
    testsRun++;
    if (testErrors == 0) begin
      $display("test %s: ok", curTest);
    end else begin
      $display("test %s: %0d errors", curTest, testErrors);
      testsFailed++;
    end
  endtask

  initial begin
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] n1;
    logic [31:0] n2;
    logic [31:0] rnd;
    seed = 56;
    rstN = 1'b0;
    instrValid = 1'b0;
    instr = '0;
    pc = '0;
    expWb = '0;
    expRedir = '0;
    expWbValid = 1'b0;
    expRedirValid = 1'b0;
    killThrough = 0;
    pcNext = 32'h0040_0000;
    testsRun = 0;
    testsFailed = 0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    repeat (4) @(posedge Clk);
    @(negedge Clk);
    rstN = 1'b1;

    startTest("idle");
    repeat (8) stepCycle(1'b0, 32'h0);
    finishTest();

    startTest("alu");
    v1 = $random(seed);
    v2 = $random(seed);
    n1 = $random(seed) | 32'h8000_0000;
    n2 = $random(seed) | 32'h8000_0000;
    loadConst(5'd1, v1);
    loadConst(5'd2, v2);
    loadConst(5'd3, n1);
    loadConst(5'd4, n2);
    issue(encR(mipsIsaPkg::fnAddu, 5'd5, 5'd1, 5'd2));
    issue(encR(mipsIsaPkg::fnSubu, 5'd6, 5'd1, 5'd2));
    issue(encR(mipsIsaPkg::fnAnd, 5'd7, 5'd1, 5'd2));
    issue(encR(mipsIsaPkg::fnOr, 5'd8, 5'd1, 5'd2));
    issue(encR(mipsIsaPkg::fnSlt, 5'd9, 5'd1, 5'd2));
    // Both operands negative
    issue(encR(mipsIsaPkg::fnSlt, 5'd10, 5'd3, 5'd4));
    issue(encR(mipsIsaPkg::fnSlt, 5'd11, 5'd4, 5'd3));
    // Negative against zero tells signed from unsigned
    issue(encR(mipsIsaPkg::fnSlt, 5'd12, 5'd3, 5'd0));
    finishTest();

    startTest("immediate");
    issue(encI(mipsIsaPkg::opAddiu, 5'd13, 5'd1, 16'h8001));
    // Reads r13 exactly two cycles after it was issued
    issue(encI(mipsIsaPkg::opAddiu, 5'd16, 5'd13, 16'h0005));
    issue(encI(mipsIsaPkg::opAndi, 5'd14, 5'd3, 16'hf0f0));
    issue(encI(mipsIsaPkg::opOri, 5'd15, 5'd0, 16'h8000));
    finishTest();

    startTest("regZero");
    issue(encI(mipsIsaPkg::opAddiu, 5'd0, 5'd1, 16'h0007));
    issue(encR(mipsIsaPkg::fnOr, 5'd17, 5'd0, 5'd0));
    issue(encR(mipsIsaPkg::fnAddu, 5'd18, 5'd0, 5'd2));
    finishTest();

    startTest("branch");
    rnd = $random(seed);
    stepCycle(1'b1, encI(mipsIsaPkg::opBeq, 5'd1, 5'd1, rnd[15:0]));
    stepCycle(1'b1, encI(mipsIsaPkg::opAddiu, 5'd22, 5'd0, 16'h0011));
    stepCycle(1'b1, encI(mipsIsaPkg::opAddiu, 5'd23, 5'd0, 16'h0022));
    issue(encI(mipsIsaPkg::opAddiu, 5'd24, 5'd0, 16'h0033));
    rnd = $random(seed);
    pcNext = {4'ha, rnd[27:4], 4'h0};
    rnd = $random(seed);
    stepCycle(1'b1, {mipsIsaPkg::opJ, rnd[25:0]});
    stepCycle(1'b1, encI(mipsIsaPkg::opAddiu, 5'd22, 5'd0, 16'h0044));
    stepCycle(1'b1, encI(mipsIsaPkg::opAddiu, 5'd23, 5'd0, 16'h0055));
    issue(encI(mipsIsaPkg::opAddiu, 5'd24, 5'd0, 16'h0066));
    // Not taken, so both followers retire
    stepCycle(1'b1, encI(mipsIsaPkg::opBne, 5'd1, 5'd1, 16'h0010));
    stepCycle(1'b1, encI(mipsIsaPkg::opAddiu, 5'd25, 5'd0, 16'h0077));
    stepCycle(1'b1, encI(mipsIsaPkg::opAddiu, 5'd26, 5'd0, 16'h0088));
    finishTest();

    $display("tests run %0d, passed %0d, failed %0d",
             testsRun, testsRun - testsFailed, testsFailed);
    if (testsFailed == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* list.f */
verilog/mipsIsaPkg.sv
verilog/pipePkg.sv
verilog/pipeStageReg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/pipeCore.sv
sim/pipeCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= pipeCoreTb
LINT_TOP  ?= pipeCore
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)
